/* Bender.yml */
package:
  name: neuron

sources:
  - files:
      - hdl/neuronPkg.sv
      - hdl/weightRom.sv
      - hdl/inputCounter.sv
      - hdl/macUnit.sv
      - hdl/neuronFsm.sv
      - hdl/neuronRegs.sv
      - hdl/neuronTop.sv

  - target: test
    files:
      - tb/neuronTb.sv

/* hdl/inputCounter.sv */
`timescale 1ns/1ps

module inputCounter import neuronPkg::*; #(
	parameter int NUM_INPUTS = 8,
	localparam int IDX_W = idxWidth(NUM_INPUTS)
) (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic advance,
	output logic [IDX_W-1:0] index,
	output logic last
);

	always_ff @(posedge clk)
	begin
		if (reset)
			index <= '0;
		else if (clear)
			index <= '0;
		else if (advance)
			index <= index + 1'b1;
	end

	assign last = (index == IDX_W'(NUM_INPUTS - 1));

	// The FSM must stop advancing once last is seen
	assert property (@(posedge clk) disable iff (reset) int'(index) < NUM_INPUTS)
		else $error("input index ran past the buffer");

endmodule

/* hdl/macUnit.sv */
`timescale 1ns/1ps

module macUnit import neuronPkg::*; (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic accumulate,
	input logic finish,
	input dataWord inputWord,
	input dataWord weight,
	output dataWord result
);

	logic signed [2*DATA_W-1:0] fullProduct;
	dataWord product;
	dataWord acc;

	assign fullProduct = inputWord * weight;
	assign product = fullProduct[DATA_W-1:0]; // Keep low word only

	always_ff @(posedge clk)
	begin
		if (reset)
			acc <= '0;
		else if (clear)
			acc <= BIAS;
		else if (accumulate)
			acc <= acc + product; // Wraps at 16 bits
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			result <= '0;
		else if (finish)
		begin
			if (acc[DATA_W-1])
				result <= '0; // Rectifier
			else
				result <= acc;
		end
	end

endmodule

/* hdl/neuronFsm.sv */
`timescale 1ns/1ps

module neuronFsm (
	input logic clk,
	input logic reset,
	input logic startPulse,
	input logic last,
	output logic clear,
	output logic advance,
	output logic accumulate,
	output logic finish,
	output logic busy,
	output logic done
);

	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_CLEAR = 3'd1;
	localparam logic [2:0] ST_ACC = 3'd2;
	localparam logic [2:0] ST_FINISH = 3'd3;
	localparam logic [2:0] ST_DONE = 3'd4;

	logic [2:0] state;
	logic [2:0] nextState;

	always_comb
	begin
		nextState = state;
		case (state)
			ST_IDLE, ST_DONE:
				if (startPulse)
					nextState = ST_CLEAR;
			ST_CLEAR:
				nextState = ST_ACC;
			ST_ACC:
				if (last)
					nextState = ST_FINISH; // Final product taken this cycle
			ST_FINISH:
				nextState = ST_DONE;
			default:
				nextState = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= ST_IDLE;
		else
			state <= nextState;
	end

	assign clear = (state == ST_CLEAR);
	assign accumulate = (state == ST_ACC);
	assign advance = (state == ST_ACC) && !last; // Step index up to the last input
	assign finish = (state == ST_FINISH);
	assign busy = (state == ST_ACC) || (state == ST_FINISH);
	assign done = (state == ST_DONE); // Held until the next start

	assert property (@(posedge clk) disable iff (reset) finish |=> done)
		else $error("finish not followed by done");

endmodule

/* hdl/neuronPkg.sv */
package neuronPkg;

	localparam int DATA_W = 16;
	typedef logic signed [DATA_W-1:0] dataWord; // Two's-complement sample

	localparam int ADDR_W = 5;
	localparam int MAX_INPUTS = 16; // Size of the weight table

	localparam logic [ADDR_W-1:0] ADDR_CTRL = 5'd16;
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 5'd17;
	localparam logic [ADDR_W-1:0] ADDR_RESULT = 5'd18;

	localparam int CTRL_START = 0;
	localparam int STATUS_BUSY = 0;
	localparam int STATUS_DONE = 1;

	localparam dataWord WEIGHTS [0:MAX_INPUTS-1] = '{
		-62, -393, 216, 493, 87, 381, -60, 35,
		-248, -151, -42, -191, 31, 13, -139, -163
	};

	localparam dataWord BIAS = -73;

	// Index width for a buffer of n words, never below one bit
	function automatic int idxWidth(input int n);
		return (n > 1) ? $clog2(n) : 1;
	endfunction

endpackage

/* hdl/neuronRegs.sv */
`timescale 1ns/1ps

module neuronRegs import neuronPkg::*; #(
	parameter int NUM_INPUTS = 8,
	localparam int IDX_W = idxWidth(NUM_INPUTS)
) (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [ADDR_W-1:0] adr,
	input dataWord datIn,
	output dataWord datOut,
	output logic ack,
	input logic busy,
	input logic done,
	input dataWord result,
	input logic [IDX_W-1:0] index,
	output logic startPulse,
	output dataWord inputWord
);

	dataWord buffer [NUM_INPUTS];
	logic request;
	logic inBuffer;
	dataWord readWord;

	assign request = cyc && stb && !ack; // New access, not yet acknowledged
	assign inBuffer = adr < ADDR_W'(NUM_INPUTS);

	// Start takes effect at the ack edge, so the FSM sees the request cycle
	assign startPulse = request && we && (adr == ADDR_CTRL) && datIn[CTRL_START] && !busy;

	assign inputWord = buffer[index]; // Operand for the MAC

	always_comb
	begin
		readWord = '0; // Undefined addresses read zero
		if (inBuffer)
			readWord = buffer[adr[IDX_W-1:0]];
		else if (adr == ADDR_STATUS)
		begin
			readWord[STATUS_BUSY] = busy;
			readWord[STATUS_DONE] = done;
		end
		else if (adr == ADDR_RESULT)
			readWord = result;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack <= 1'b0;
			for (int i = 0; i < NUM_INPUTS; i++)
				buffer[i] <= '0;
		end
		else
		begin
			ack <= request; // One-shot ack
			if (request && we && inBuffer && !busy)
				buffer[adr[IDX_W-1:0]] <= datIn; // Frozen while computing
		end
	end

	always_ff @(posedge clk)
	begin
		if (request && !we)
			datOut <= readWord;
	end

	assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
		else $error("ack high for two consecutive cycles");

	// A start launches a run that shows busy two cycles later
	assert property (@(posedge clk) disable iff (reset) startPulse |-> !busy ##2 busy)
		else $error("start accepted while busy or run did not begin");

endmodule

/* hdl/neuronTop.sv */
`timescale 1ns/1ps

module neuronTop import neuronPkg::*; #(
	parameter int NUM_INPUTS = 8,
	localparam int IDX_W = idxWidth(NUM_INPUTS)
) (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [ADDR_W-1:0] adr,
	input dataWord datIn,
	output dataWord datOut,
	output logic ack
);

	logic startPulse;
	logic busy;
	logic done;
	logic clear;
	logic advance;
	logic accumulate;
	logic finish;
	logic last;
	logic [IDX_W-1:0] index;
	dataWord inputWord;
	dataWord weight;
	dataWord result;

	neuronRegs #(.NUM_INPUTS(NUM_INPUTS)) regs0 (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.datOut(datOut),
		.ack(ack),
		.busy(busy),
		.done(done),
		.result(result),
		.index(index),
		.startPulse(startPulse),
		.inputWord(inputWord)
	);

	neuronFsm fsm0 (
		.clk(clk),
		.reset(reset),
		.startPulse(startPulse),
		.last(last),
		.clear(clear),
		.advance(advance),
		.accumulate(accumulate),
		.finish(finish),
		.busy(busy),
		.done(done)
	);

	inputCounter #(.NUM_INPUTS(NUM_INPUTS)) counter0 (
		.clk(clk),
		.reset(reset),
		.clear(clear),
		.advance(advance),
		.index(index),
		.last(last)
	);

	weightRom #(.NUM_INPUTS(NUM_INPUTS)) rom0 (
		.index(index),
		.weight(weight)
	);

	macUnit mac0 (
		.clk(clk),
		.reset(reset),
		.clear(clear),
		.accumulate(accumulate),
		.finish(finish),
		.inputWord(inputWord),
		.weight(weight),
		.result(result)
	);

endmodule

/* hdl/weightRom.sv */
`timescale 1ns/1ps

module weightRom import neuronPkg::*; #(
	parameter int NUM_INPUTS = 8,
	localparam int IDX_W = idxWidth(NUM_INPUTS)
) (
	input logic [IDX_W-1:0] index,
	output dataWord weight
);

	if (NUM_INPUTS < 1 || NUM_INPUTS > MAX_INPUTS)
	begin : gBadCount
		$error("NUM_INPUTS must lie between 1 and MAX_INPUTS");
	end

	assign weight = WEIGHTS[index]; // Constant table, no latency

endmodule

/* project.f */
hdl/neuronPkg.sv
hdl/weightRom.sv
hdl/inputCounter.sv
hdl/macUnit.sv
hdl/neuronFsm.sv
hdl/neuronRegs.sv
hdl/neuronTop.sv
tb/neuronTb.sv

/* tb/neuronTb.sv */
`timescale 1ns/1ps

module neuronTb import neuronPkg::*; ();

	localparam int NUM = 8;
	localparam int CLK_PERIOD = 100;
	localparam int ACK_WAIT = 4; // Cycles allowed for a bus ack
	localparam int POLL_LIMIT = 30;
	localparam int RANDOM_RUNS = 20;

	// 26 runs of about 32 cycles each plus about 70 cycles of register
	// traffic come to roughly 950 cycles, so 3000 leaves about three times that
	localparam int CYCLE_LIMIT = 3000;

	localparam int REF_BIAS = -73;
	localparam int REF_WEIGHTS [0:NUM-1] = '{-62, -393, 216, 493, 87, 381, -60, 35};

	logic clk;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [ADDR_W-1:0] adr;
	dataWord datIn;
	dataWord datOut;
	logic ack;

	dataWord vec [NUM]; // Current input vector
	int errorCount;
	int testCount;
	int testStartErrors;
	int cycleCount;
	integer seed;

	neuronTop #(.NUM_INPUTS(NUM)) dut0 (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.datOut(datOut),
		.ack(ack)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= CYCLE_LIMIT)
		begin
			$display("Run stopped after %0d cycles because the tests did not finish",
				cycleCount);
			$display("TB FAILED");
			$finish;
		end
	end

	// Expected output from the neuron rules, with wraparound taken at the end
	function automatic dataWord expectedResult();
		int total;
		dataWord word;
		total = REF_BIAS;
		for (int i = 0; i < NUM; i++)
			total += int'(vec[i]) * REF_WEIGHTS[i];
		word = total[15:0]; // Only the low word survives
		if (word[15])
			word = '0; // Rectifier
		return word;
	endfunction

	// One Wishbone classic cycle, started and ended at a falling edge
	task automatic busAccess(input logic isWrite, input logic [ADDR_W-1:0] addr,
		input dataWord wdata, output dataWord rdata);
		int waited;
		waited = 1;
		rdata = '0;
		cyc = 1'b1;
		stb = 1'b1;
		we = isWrite;
		adr = addr;
		datIn = wdata;
		@(negedge clk);
		while (!ack && waited < ACK_WAIT)
		begin
			waited++;
			@(negedge clk);
		end
		if (ack)
			rdata = datOut;
		else
		begin
			$display("No ack from the DUT within %0d cycles for %s at address %0d",
				ACK_WAIT, isWrite ? "a write" : "a read", addr);
			errorCount++;
		end
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		@(negedge clk); // Idle cycle
	endtask

	task automatic wbWrite(input logic [ADDR_W-1:0] addr, input dataWord data);
		dataWord unused;
		busAccess(1'b1, addr, data, unused);
	endtask

	task automatic wbRead(input logic [ADDR_W-1:0] addr, output dataWord data);
		busAccess(1'b0, addr, '0, data);
	endtask

	task automatic loadInputs();
		for (int i = 0; i < NUM; i++)
			wbWrite(ADDR_W'(i), vec[i]);
	endtask

	task automatic startRun();
		wbWrite(ADDR_CTRL, dataWord'(1 << CTRL_START));
	endtask

	task automatic waitDone(output dataWord status);
		int polls;
		polls = 0;
		status = '0;
		while (!status[STATUS_DONE] && polls < POLL_LIMIT)
		begin
			wbRead(ADDR_STATUS, status);
			polls++;
		end
		if (!status[STATUS_DONE])
		begin
			$display("Done bit never set after %0d status reads", POLL_LIMIT);
			errorCount++;
		end
	endtask

	task automatic runNeuron(output dataWord res);
		dataWord status;
		loadInputs();
		startRun();
		waitDone(status);
		wbRead(ADDR_RESULT, res);
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (errorCount == testStartErrors)
			$display("Test %0d %s: ok", testCount, name);
		else
			$display("Test %0d %s: %0d errors", testCount, name,
				errorCount - testStartErrors);
		testStartErrors = errorCount;
	endtask

	task automatic testReset();
		dataWord got;
		wbRead(ADDR_STATUS, got);
		if (got !== 16'h0000)
		begin
			$display("Mismatch status: got 0x%04h expected 0x0000", got);
			errorCount++;
		end
		wbRead(ADDR_RESULT, got);
		if (got !== 16'h0000)
		begin
			$display("Mismatch result: got 0x%04h expected 0x0000", got);
			errorCount++;
		end
		for (int i = 0; i < NUM; i++)
		begin
			wbRead(ADDR_W'(i), got);
			if (got !== 16'h0000)
			begin
				$display("Mismatch input[%0d]: got 0x%04h expected 0x0000", i, got);
				errorCount++;
			end
		end
		finishTest("reset values");
	endtask

	task automatic testBuffer();
		dataWord got;
		dataWord pattern;
		logic [ADDR_W-1:0] undefAddr [4];
		undefAddr = '{5'd8, 5'd15, 5'd20, 5'd31};
		for (int i = 0; i < NUM; i++)
			wbWrite(ADDR_W'(i), dataWord'(i * 16'h1357) ^ 16'hc0de);
		for (int i = 0; i < NUM; i++)
		begin
			pattern = dataWord'(i * 16'h1357) ^ 16'hc0de;
			wbRead(ADDR_W'(i), got);
			if (got !== pattern)
			begin
				$display("Mismatch input[%0d]: got 0x%04h expected 0x%04h", i, got, pattern);
				errorCount++;
			end
		end
		wbWrite(5'd20, 16'hbeef); // Acked and dropped
		for (int k = 0; k < 4; k++)
		begin
			wbRead(undefAddr[k], got);
			if (got !== 16'h0000)
			begin
				$display("Mismatch datOut at address %0d: got 0x%04h expected 0x0000",
					undefAddr[k], got);
				errorCount++;
			end
		end
		finishTest("buffer read-back");
	endtask

	task automatic testPositive();
		dataWord got;
		dataWord exp;
		dataWord status;
		for (int i = 0; i < NUM; i++)
			vec[i] = 16'd1;
		runNeuron(got);
		exp = expectedResult();
		if (got !== exp || got !== 16'h0270)
		begin
			$display("Mismatch result: got 0x%04h expected 0x%04h", got, exp);
			errorCount++;
		end
		wbRead(ADDR_STATUS, status);
		if (status !== 16'h0002)
		begin
			$display("Mismatch status: got 0x%04h expected 0x0002", status);
			errorCount++;
		end
		for (int i = 0; i < NUM; i++)
			vec[i] = dataWord'(i + 1);
		runNeuron(got);
		exp = expectedResult();
		if (got !== exp)
		begin
			$display("Mismatch result: got 0x%04h expected 0x%04h", got, exp);
			errorCount++;
		end
		finishTest("positive vectors");
	endtask

	task automatic testNegative();
		dataWord got;
		dataWord exp;
		dataWord literal [3];
		literal = '{16'h0000, 16'h0000, 16'h0d53};
		for (int v = 0; v < 3; v++)
		begin
			for (int i = 0; i < NUM; i++)
				vec[i] = '0;
			// Sum is the bias alone, then 34437 past the top, then 68947 wrapped
			if (v == 1)
				vec[3] = 16'd70;
			else if (v == 2)
				vec[3] = 16'd140;
			runNeuron(got);
			exp = expectedResult();
			if (got !== exp || got !== literal[v])
			begin
				$display("Mismatch result (vector %0d): got 0x%04h expected 0x%04h",
					v, got, exp);
				errorCount++;
			end
		end
		finishTest("negative and wraparound");
	endtask

	task automatic testBusy();
		dataWord got;
		dataWord exp;
		dataWord status;
		for (int i = 0; i < NUM; i++)
			vec[i] = dataWord'(3 * i + 2);
		loadInputs();
		startRun();
		wbRead(ADDR_STATUS, status);
		if (status !== 16'h0001)
		begin
			$display("Mismatch status: got 0x%04h expected 0x0001", status);
			errorCount++;
		end
		startRun(); // Must not restart
		wbWrite(5'd0, 16'h7fff); // Must not land in the buffer
		waitDone(status);
		wbRead(ADDR_RESULT, got);
		exp = expectedResult();
		if (got !== exp)
		begin
			$display("Mismatch result: got 0x%04h expected 0x%04h", got, exp);
			errorCount++;
		end
		wbRead(5'd0, got);
		if (got !== vec[0])
		begin
			$display("Mismatch input[0]: got 0x%04h expected 0x%04h", got, vec[0]);
			errorCount++;
		end
		finishTest("access while busy");
	endtask

	task automatic testRandom();
		dataWord got;
		dataWord exp;
		for (int n = 0; n < RANDOM_RUNS; n++)
		begin
			for (int i = 0; i < NUM; i++)
				vec[i] = dataWord'($random(seed));
			runNeuron(got);
			exp = expectedResult();
			if (got !== exp)
			begin
				$display("Mismatch result (random vector %0d): got 0x%04h expected 0x%04h",
					n, got, exp);
				errorCount++;
			end
		end
		finishTest("random vectors");
	endtask

	initial
	begin
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		errorCount = 0;
		testCount = 0;
		testStartErrors = 0;
		cycleCount = 0;
		seed = 32'ha9c5_678e;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		testReset();
		testBuffer();
		testPositive();
		testNegative();
		testBusy();
		testRandom();

		$display("Tests run %0d, errors %0d", testCount, errorCount);
		if (errorCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
